/* mma_pkg.sv */
/*
 * Matrix multiply accelerator shared types
 * Link byte, matrix word and dimension widths plus the command codes
 * carried on the byte stream
 */
package mma_pkg;

    typedef logic [7:0] byte_t;           // One link byte
    typedef logic signed [31:0] word_t;   // Matrix value or transferred word
    typedef logic [15:0] dim_t;           // Dimension or element index

    // Codes seen on the link, both directions
    typedef enum logic [7:0] {
        CMD_LOAD_A   = 8'h01,             // Host sends matrix A
        CMD_LOAD_B   = 8'h02,             // Host sends matrix B
        CMD_MULTIPLY = 8'h03,             // Compute R = A * B
        CMD_READ_R   = 8'h04,             // Host asks for R
        RSP_DONE     = 8'h05,             // Multiply finished
        RSP_ACK      = 8'h06,             // Load accepted
        RSP_ERR      = 8'hAA              // Dimension mismatch
    } cmd_e;

endpackage

/* matrix_ram.sv */
/*
 * Matrix memory
 * Single-port store for one matrix in row-major order, registered read
 */
`timescale 1ns/10ps

module matrix_ram
    import mma_pkg::*;
#(
    parameter int MAX_DIM = 8,
    localparam int DEPTH = MAX_DIM * MAX_DIM,
    localparam int AW = $clog2(DEPTH)
) (
    input  logic          CLK100MHZ,
    input  logic          we_i,        // Write strobe
    input  logic [AW-1:0] addr_i,      // Row-major element index
    input  word_t         wdata_i,
    output word_t         rdata_o      // Valid one cycle after addr_i
);

    word_t mem_q [DEPTH];              // Element storage

    always_ff @(posedge CLK100MHZ) begin
        if (we_i) begin
            mem_q[addr_i] <= wdata_i;  // Write port
        end
        rdata_o <= mem_q[addr_i];      // Read first, old data on collision
    end

    // Writes must stay inside the MAX_DIM x MAX_DIM array
    assert property (@(posedge CLK100MHZ) we_i |-> (addr_i < DEPTH))
        else $error("matrix_ram write beyond depth, addr %0d", addr_i);

endmodule

/* word_rx.sv */
/*
 * Receive word framer
 * Packs four link bytes, first byte most significant, into one word
 */
`timescale 1ns/10ps

module word_rx
    import mma_pkg::*;
(
    input  logic  CLK100MHZ,
    input  logic  rst_i,
    input  logic  collect_i,      // Level from controller, low clears count
    input  byte_t rx_data_i,
    input  logic  rx_valid_i,     // One strobe per byte
    output word_t word_o,
    output logic  word_valid_o    // One-cycle pulse per assembled word
);

    logic [1:0]  cnt_q;           // Bytes held so far
    logic [23:0] sh_q;            // Upper three bytes in arrival order

    always_ff @(posedge CLK100MHZ) begin
        word_valid_o <= 1'b0;                          // Pulse by default
        if (rst_i) begin
            cnt_q <= 2'd0;
        end else if (!collect_i) begin
            cnt_q <= 2'd0;                             // Not in a payload
        end else if (rx_valid_i) begin
            cnt_q <= cnt_q + 2'd1;                     // Wraps after fourth
            sh_q  <= {sh_q[15:0], rx_data_i};          // Shift in at bottom
            if (cnt_q == 2'd3) begin
                word_o       <= {sh_q, rx_data_i};     // Big-endian word
                word_valid_o <= 1'b1;
            end
        end
    end

endmodule

/* word_tx.sv */
/*
 * Transmit framer
 * Sends a word as four bytes MSB first, or a single response byte,
 * pacing each byte on the outside transmitter's busy level
 */
`timescale 1ns/10ps

module word_tx
    import mma_pkg::*;
(
    input  logic  CLK100MHZ,
    input  logic  rst_i,
    input  logic  send_word_i,    // Start four-byte send
    input  logic  send_byte_i,    // Start single-byte send of low byte
    input  word_t tx_word_i,
    input  logic  tx_busy_i,      // Transmitter occupied
    output byte_t tx_data_o,
    output logic  tx_valid_o,     // One pulse per byte
    output logic  done_o          // Last byte out and link free again
);

    typedef enum logic [1:0] {TX_IDLE, TX_GAP, TX_WAIT} tx_state_e;

    tx_state_e  state_q;
    logic [1:0] left_q;           // Bytes still to send
    word_t      sh_q;             // Remaining bytes, next one on top

    always_ff @(posedge CLK100MHZ) begin
        tx_valid_o <= 1'b0;
        done_o     <= 1'b0;
        if (rst_i) begin
            state_q <= TX_IDLE;
        end else begin
            case (state_q)
                TX_IDLE: begin
                    if (send_word_i) begin
                        tx_data_o  <= tx_word_i[31:24];           // MSB first
                        sh_q       <= tx_word_i <<< 8;
                        left_q     <= 2'd3;
                        tx_valid_o <= 1'b1;
                        state_q    <= TX_GAP;
                    end else if (send_byte_i) begin
                        tx_data_o  <= tx_word_i[7:0];
                        left_q     <= 2'd0;
                        tx_valid_o <= 1'b1;
                        state_q    <= TX_GAP;
                    end
                end
                TX_GAP: state_q <= TX_WAIT;     // Busy shows up one cycle late
                TX_WAIT: begin
                    if (!tx_busy_i) begin
                        if (left_q == 2'd0) begin
                            done_o  <= 1'b1;
                            state_q <= TX_IDLE;
                        end else begin
                            tx_data_o  <= sh_q[31:24];
                            sh_q       <= sh_q <<< 8;
                            left_q     <= left_q - 2'd1;
                            tx_valid_o <= 1'b1;
                            state_q    <= TX_GAP;
                        end
                    end
                end
                default: state_q <= TX_IDLE;
            endcase
        end
    end

    // Controller must wait for done_o before the next send
    assert property (@(posedge CLK100MHZ) disable iff (rst_i)
        (send_word_i || send_byte_i) |-> (state_q == TX_IDLE))
        else $error("word_tx send request while a send is in progress");

endmodule

/* mac_unit.sv */
/*
 * Dot-product MAC
 * Pipelined signed multiplier feeding a wrapping 32-bit accumulator
 */
`timescale 1ns/10ps

module mac_unit
    import mma_pkg::*;
#(
    parameter int MAC_LATENCY = 3      // Multiplier stages
) (
    input  logic  CLK100MHZ,
    input  logic  rst_i,
    input  word_t op_a_i,
    input  word_t op_b_i,
    input  logic  op_valid_i,
    input  logic  op_last_i,           // Final pair of this dot product
    output word_t sum_o,
    output logic  sum_valid_o          // MAC_LATENCY + 1 after last pair
);

    word_t                  prod_q [MAC_LATENCY];   // Product pipeline
    logic [MAC_LATENCY-1:0] vld_q;                  // Valid per stage
    logic [MAC_LATENCY-1:0] last_q;                 // Last flag per stage
    word_t                  acc_q;                  // Running sum

    always_ff @(posedge CLK100MHZ) begin
        prod_q[0] <= op_a_i * op_b_i;               // Low 32 bits, wraps
        for (int s = 1; s < MAC_LATENCY; s++) begin
            prod_q[s] <= prod_q[s-1];
        end
    end

    always_ff @(posedge CLK100MHZ) begin
        sum_valid_o <= 1'b0;
        if (rst_i) begin
            vld_q  <= '0;
            last_q <= '0;
            acc_q  <= '0;
        end else begin
            vld_q[0]  <= op_valid_i;
            last_q[0] <= op_valid_i & op_last_i;
            for (int s = 1; s < MAC_LATENCY; s++) begin
                vld_q[s]  <= vld_q[s-1];
                last_q[s] <= last_q[s-1];
            end
            if (vld_q[MAC_LATENCY-1]) begin
                if (last_q[MAC_LATENCY-1]) begin
                    sum_o       <= acc_q + prod_q[MAC_LATENCY-1];
                    sum_valid_o <= 1'b1;
                    acc_q       <= '0;                        // Ready for next element
                end else begin
                    acc_q <= acc_q + prod_q[MAC_LATENCY-1];
                end
            end
        end
    end

endmodule

/* mma_controller.sv */
/*
 * Accelerator controller
 * Decodes link commands, loads A and B, sequences dot products through
 * the MAC into R and streams R back out
 */
`timescale 1ns/10ps

module mma_controller
    import mma_pkg::*;
#(
    parameter int MAX_DIM = 8,
    localparam int AW = $clog2(MAX_DIM * MAX_DIM)
) (
    input  logic          CLK100MHZ,
    input  logic          rst_i,
    input  byte_t         rx_data_i,
    input  logic          rx_valid_i,
    output logic          collect_o,     // Payload bytes go to word_rx
    input  word_t         word_i,
    input  logic          word_valid_i,
    output logic          send_word_o,
    output logic          send_byte_o,
    output word_t         tx_word_o,
    input  logic          tx_done_i,
    output logic          a_we_o,
    output logic [AW-1:0] a_addr_o,
    output word_t         a_wdata_o,
    output logic          b_we_o,
    output logic [AW-1:0] b_addr_o,
    output word_t         b_wdata_o,
    output logic          r_we_o,
    output logic [AW-1:0] r_addr_o,
    output word_t         r_wdata_o,
    input  word_t         a_rdata_i,
    input  word_t         b_rdata_i,
    input  word_t         r_rdata_i,
    output word_t         op_a_o,
    output word_t         op_b_o,
    output logic          op_valid_o,
    output logic          op_last_o,
    input  word_t         sum_i,
    input  logic          sum_valid_i
);

    typedef enum logic [3:0] {
        ST_IDLE, ST_LOAD_DIMS, ST_LOAD_DATA, ST_RESPOND, ST_CHECK_DIMS,
        ST_ISSUE_DOT, ST_WAIT_SUM, ST_READ_DIMS, ST_READ_DATA
    } ctrl_state_e;

    ctrl_state_e   state_q;
    dim_t          a_m_q, a_n_q, b_m_q, b_n_q, r_m_q, r_n_q;   // Stored shapes
    dim_t          i_q, j_q, k_q;       // R row, R column, inner index
    dim_t          cnt_q;               // Load or readout element count
    logic          sel_b_q;             // Load target is B
    logic          first_q;             // First step of a sub-sequence
    logic          iss_q, iss_last_q;   // Pair issued, aligned with address
    logic [AW-1:0] a_addr_q, b_addr_q, r_addr_q;
    word_t         wdata_q;             // Shared memory write data
    dim_t          ld_tot, r_tot;       // Element counts

    assign ld_tot    = sel_b_q ? b_m_q * b_n_q : a_m_q * a_n_q;
    assign r_tot     = r_m_q * r_n_q;
    assign collect_o = (state_q == ST_LOAD_DIMS) || (state_q == ST_LOAD_DATA);
    assign a_addr_o  = a_addr_q;
    assign b_addr_o  = b_addr_q;
    assign r_addr_o  = r_addr_q;
    assign a_wdata_o = wdata_q;
    assign b_wdata_o = wdata_q;
    assign r_wdata_o = wdata_q;
    assign op_a_o    = a_rdata_i;       // Memory data lines up with op_valid_o
    assign op_b_o    = b_rdata_i;

    always_ff @(posedge CLK100MHZ) begin
        a_we_o      <= 1'b0;             // Strobes default low
        b_we_o      <= 1'b0;
        r_we_o      <= 1'b0;
        send_word_o <= 1'b0;
        send_byte_o <= 1'b0;
        iss_q       <= 1'b0;
        iss_last_q  <= 1'b0;
        op_valid_o  <= iss_q;            // One cycle for the memory read
        op_last_o   <= iss_last_q;
        if (rst_i) begin
            state_q    <= ST_IDLE;
            {a_m_q, a_n_q, b_m_q, b_n_q, r_m_q, r_n_q} <= '0;
            sel_b_q    <= 1'b0;
            first_q    <= 1'b0;
            op_valid_o <= 1'b0;
            op_last_o  <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (rx_valid_i) begin
                        case (rx_data_i)
                            CMD_LOAD_A, CMD_LOAD_B: begin
                                sel_b_q <= (rx_data_i == CMD_LOAD_B);
                                first_q <= 1'b1;
                                state_q <= ST_LOAD_DIMS;
                            end
                            CMD_MULTIPLY: state_q <= ST_CHECK_DIMS;
                            CMD_READ_R: begin
                                send_word_o <= 1'b1;
                                tx_word_o   <= word_t'(r_m_q);    // Rows first
                                first_q     <= 1'b1;
                                r_addr_q    <= '0;                // Prefetch element 0
                                state_q     <= ST_READ_DIMS;
                            end
                            default: ;                            // Unknown code ignored
                        endcase
                    end
                end
                ST_LOAD_DIMS: begin
                    if (word_valid_i) begin
                        first_q <= 1'b0;
                        cnt_q   <= '0;
                        if (first_q && sel_b_q) begin
                            b_m_q <= dim_t'(word_i);
                        end else if (first_q) begin
                            a_m_q <= dim_t'(word_i);
                        end else begin
                            if (sel_b_q) begin
                                b_n_q <= dim_t'(word_i);
                            end else begin
                                a_n_q <= dim_t'(word_i);
                            end
                            state_q <= ST_LOAD_DATA;
                        end
                    end
                end
                ST_LOAD_DATA: begin
                    if (word_valid_i) begin
                        a_we_o   <= !sel_b_q;
                        b_we_o   <= sel_b_q;
                        a_addr_q <= AW'(cnt_q);
                        b_addr_q <= AW'(cnt_q);
                        wdata_q  <= word_i;
                        cnt_q    <= cnt_q + 1'b1;
                        if (cnt_q == ld_tot - 1'b1) begin
                            send_byte_o <= 1'b1;
                            tx_word_o   <= word_t'(RSP_ACK);
                            state_q     <= ST_RESPOND;
                        end
                    end
                end
                ST_RESPOND: begin
                    if (tx_done_i) begin
                        state_q <= ST_IDLE;
                    end
                end
                ST_CHECK_DIMS: begin
                    if (a_n_q != b_m_q) begin
                        send_byte_o <= 1'b1;              // R left as it was
                        tx_word_o   <= word_t'(RSP_ERR);
                        state_q     <= ST_RESPOND;
                    end else begin
                        r_m_q <= a_m_q;
                        r_n_q <= b_n_q;
                        i_q   <= '0;
                        j_q   <= '0;
                        k_q   <= '0;
                        if (a_n_q == '0) begin            // Nothing loaded, empty R
                            send_byte_o <= 1'b1;
                            tx_word_o   <= word_t'(RSP_DONE);
                            state_q     <= ST_RESPOND;
                        end else begin
                            state_q <= ST_ISSUE_DOT;
                        end
                    end
                end
                ST_ISSUE_DOT: begin
                    iss_q    <= 1'b1;                     // One pair per cycle
                    a_addr_q <= AW'(i_q * a_n_q + k_q);   // A[i][k]
                    b_addr_q <= AW'(k_q * b_n_q + j_q);   // B[k][j]
                    if (k_q == a_n_q - 1'b1) begin
                        iss_last_q <= 1'b1;
                        k_q        <= '0;
                        state_q    <= ST_WAIT_SUM;
                    end else begin
                        k_q <= k_q + 1'b1;
                    end
                end
                ST_WAIT_SUM: begin
                    if (sum_valid_i) begin
                        r_we_o   <= 1'b1;
                        r_addr_q <= AW'(i_q * r_n_q + j_q);
                        wdata_q  <= sum_i;
                        state_q  <= ST_ISSUE_DOT;
                        if (j_q == r_n_q - 1'b1) begin
                            j_q <= '0;
                            i_q <= i_q + 1'b1;
                            if (i_q == r_m_q - 1'b1) begin  // Last element
                                send_byte_o <= 1'b1;
                                tx_word_o   <= word_t'(RSP_DONE);
                                state_q     <= ST_RESPOND;
                            end
                        end else begin
                            j_q <= j_q + 1'b1;
                        end
                    end
                end
                ST_READ_DIMS: begin
                    if (tx_done_i) begin
                        if (first_q) begin
                            first_q     <= 1'b0;
                            send_word_o <= 1'b1;
                            tx_word_o   <= word_t'(r_n_q);
                        end else if (r_tot == '0) begin
                            state_q <= ST_IDLE;           // Empty R, dims only
                        end else begin
                            cnt_q   <= '0;
                            first_q <= 1'b1;              // Element send pending
                            state_q <= ST_READ_DATA;
                        end
                    end
                end
                ST_READ_DATA: begin
                    if (first_q) begin
                        first_q     <= 1'b0;
                        send_word_o <= 1'b1;
                        tx_word_o   <= r_rdata_i;
                        r_addr_q    <= AW'(cnt_q + 1'b1); // Fetch during the send
                    end else if (tx_done_i) begin
                        if (cnt_q == r_tot - 1'b1) begin
                            state_q <= ST_IDLE;
                        end else begin
                            cnt_q   <= cnt_q + 1'b1;
                            first_q <= 1'b1;
                        end
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Host dimensions must fit the memories
    assert property (@(posedge CLK100MHZ) disable iff (rst_i)
        (state_q == ST_LOAD_DIMS && word_valid_i) |-> (word_i >= 1 && word_i <= MAX_DIM))
        else $error("received dimension %0d outside 1..%0d", word_i, MAX_DIM);

endmodule

/* mma_top.sv */
/*
 * Matrix multiply accelerator top level
 * Byte-stream link, controller, A/B/R memories and the MAC unit
 */
`timescale 1ns/10ps

module mma_top
    import mma_pkg::*;
#(
    parameter int MAX_DIM     = 8,   // Largest matrix side
    parameter int MAC_LATENCY = 3    // Multiplier pipeline depth
) (
    input  logic  CLK100MHZ,
    input  logic  rst_i,
    input  byte_t rx_data_i,
    input  logic  rx_valid_i,
    input  logic  tx_busy_i,
    output byte_t tx_data_o,
    output logic  tx_valid_o
);

    localparam int AW = $clog2(MAX_DIM * MAX_DIM);

    logic          collect, word_valid, send_word, send_byte, tx_done;
    word_t         word, tx_word;
    logic          a_we, b_we, r_we;
    logic [AW-1:0] a_addr, b_addr, r_addr;
    word_t         a_wdata, b_wdata, r_wdata, a_rdata, b_rdata, r_rdata;
    word_t         op_a, op_b, sum;
    logic          op_valid, op_last, sum_valid;

    mma_controller #(.MAX_DIM(MAX_DIM)) u_ctrl (
        .CLK100MHZ, .rst_i, .rx_data_i, .rx_valid_i,
        .collect_o(collect), .word_i(word), .word_valid_i(word_valid),
        .send_word_o(send_word), .send_byte_o(send_byte), .tx_word_o(tx_word),
        .tx_done_i(tx_done),
        .a_we_o(a_we), .a_addr_o(a_addr), .a_wdata_o(a_wdata),
        .b_we_o(b_we), .b_addr_o(b_addr), .b_wdata_o(b_wdata),
        .r_we_o(r_we), .r_addr_o(r_addr), .r_wdata_o(r_wdata),
        .a_rdata_i(a_rdata), .b_rdata_i(b_rdata), .r_rdata_i(r_rdata),
        .op_a_o(op_a), .op_b_o(op_b), .op_valid_o(op_valid), .op_last_o(op_last),
        .sum_i(sum), .sum_valid_i(sum_valid)
    );

    matrix_ram #(.MAX_DIM(MAX_DIM)) ram_a (
        .CLK100MHZ, .we_i(a_we), .addr_i(a_addr), .wdata_i(a_wdata), .rdata_o(a_rdata)
    );

    matrix_ram #(.MAX_DIM(MAX_DIM)) ram_b (
        .CLK100MHZ, .we_i(b_we), .addr_i(b_addr), .wdata_i(b_wdata), .rdata_o(b_rdata)
    );

    matrix_ram #(.MAX_DIM(MAX_DIM)) ram_r (
        .CLK100MHZ, .we_i(r_we), .addr_i(r_addr), .wdata_i(r_wdata), .rdata_o(r_rdata)
    );

    mac_unit #(.MAC_LATENCY(MAC_LATENCY)) u_mac (
        .CLK100MHZ, .rst_i, .op_a_i(op_a), .op_b_i(op_b), .op_valid_i(op_valid),
        .op_last_i(op_last), .sum_o(sum), .sum_valid_o(sum_valid)
    );

    word_rx u_rx (
        .CLK100MHZ, .rst_i, .collect_i(collect), .rx_data_i, .rx_valid_i,
        .word_o(word), .word_valid_o(word_valid)
    );

    word_tx u_tx (
        .CLK100MHZ, .rst_i, .send_word_i(send_word), .send_byte_i(send_byte),
        .tx_word_i(tx_word), .tx_busy_i, .tx_data_o, .tx_valid_o, .done_o(tx_done)
    );

endmodule

/* tb_mma.sv */
/*
 * Matrix multiply accelerator testbench
 * Random loads, multiplies and readouts over a modelled byte link,
 * checked against a reference model of A, B and R
 */
`timescale 1ns/10ps

module tb_mma
    import mma_pkg::*;
();

    localparam int MAX_DIM  = 8;
    localparam int ROUNDS   = 10;
    localparam int MAX_ELEM = MAX_DIM * MAX_DIM;
    // Upper bound on response bytes with two full readouts plus codes per round
    localparam int RSP_BOUND   = (ROUNDS + 1) * (2 * 4 * (2 + MAX_ELEM) + 6);
    localparam int WDOG_CYCLES = 2000 * RSP_BOUND + 10000;

    logic  CLK100MHZ = 1'b0;
    logic  rst_i;
    byte_t rx_data_i;
    logic  rx_valid_i;
    logic  tx_busy_i = 1'b0;           // Driven by the transmitter model
    byte_t tx_data_o;
    logic  tx_valid_o;

    logic [31:0] lfsr_q = 32'd40;      // Seed
    byte_t       rsp_q [$];            // Bytes seen on the tx side
    int          busy_req   = 0;       // Busy length picked for last pulse
    int          busy_left  = 0;
    logic        link_quiet = 1'b1;    // No pulse and no busy pending

    word_t a_ref [MAX_ELEM];           // Reference matrices in row-major order
    word_t b_ref [MAX_ELEM];
    word_t r_ref [MAX_ELEM];
    int    am = 0, an = 0, bm = 0, bn = 0, rm = 0, rn = 0;

    mma_top #(.MAX_DIM(MAX_DIM)) DUT (
        .CLK100MHZ, .rst_i, .rx_data_i, .rx_valid_i, .tx_busy_i, .tx_data_o, .tx_valid_o
    );

    always #5 CLK100MHZ = ~CLK100MHZ;  // 100 MHz

    // Galois LFSR for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);              // One step per bit
            v      = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // Transmitter model captures bytes at mid-cycle and picks a busy length
    always @(negedge CLK100MHZ) begin
        if (tx_valid_o) begin
            rsp_q.push_back(tx_data_o);
            busy_req = 1 + int'(rand_bits(2));       // 1 to 4 cycles
        end
        link_quiet = !tx_valid_o && (busy_req == 0) && !tx_busy_i;
    end

    // Busy rises on the cycle after the pulse
    always @(posedge CLK100MHZ) begin
        #1;
        if (busy_req != 0) begin
            busy_left = busy_req;
            busy_req  = 0;
        end
        tx_busy_i = (busy_left != 0);
        if (busy_left != 0) begin
            busy_left = busy_left - 1;
        end
    end

    task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED time %0t: %s = 0x%08h, expected 0x%08h",
                     $time, what, got, exp);
            $display("tests failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge CLK100MHZ);
            #1;                                      // Drive point
        end
    endtask

    task automatic drive_byte(input byte_t b);
        idle_cycles(int'(rand_bits(2)));             // Random rx gap
        rx_data_i  = b;
        rx_valid_i = 1'b1;
        idle_cycles(1);
        rx_valid_i = 1'b0;
    endtask

    task automatic drive_word(input word_t w);
        for (int i = 3; i >= 0; i--) begin
            drive_byte(w[8*i +: 8]);                 // Big-endian
        end
    endtask

    // Waits for n bytes, then for busy to clear and done to reach the FSM
    task automatic collect_rsp(input int n);
        while (rsp_q.size() < n) begin
            idle_cycles(1);
        end
        while (!link_quiet) begin
            idle_cycles(1);
        end
        idle_cycles(3);
        check_val("response byte count", rsp_q.size(), n);
    endtask

    task automatic pop_word(output word_t w);
        w = '0;
        repeat (4) begin
            w = {w[23:0], rsp_q.pop_front()};        // First byte ends up on top
        end
    endtask

    task automatic expect_code(input cmd_e code);
        collect_rsp(1);
        check_val("response code", rsp_q.pop_front(), code);
    endtask

    task automatic load_matrix(input bit to_b, input int m, input int n);
        word_t v;
        drive_byte(to_b ? CMD_LOAD_B : CMD_LOAD_A);
        drive_word(m);
        drive_word(n);
        for (int e = 0; e < m * n; e++) begin
            v = rand_bits(32);
            if (to_b) begin
                b_ref[e] = v;
            end else begin
                a_ref[e] = v;
            end
            drive_word(v);
        end
        if (to_b) begin
            bm = m;
            bn = n;
        end else begin
            am = m;
            an = n;
        end
        expect_code(RSP_ACK);
    endtask

    task automatic multiply_check();
        word_t acc;
        drive_byte(CMD_MULTIPLY);
        if (an != bm) begin
            expect_code(RSP_ERR);                    // R keeps its old contents
        end else begin
            rm = am;
            rn = bn;
            for (int i = 0; i < rm; i++) begin
                for (int j = 0; j < rn; j++) begin
                    acc = '0;
                    for (int k = 0; k < an; k++) begin
                        acc = acc + a_ref[i*an + k] * b_ref[k*bn + j];   // Wraps at 32 bits
                    end
                    r_ref[i*rn + j] = acc;
                end
            end
            expect_code(RSP_DONE);
        end
    endtask

    task automatic read_check();
        word_t w;
        drive_byte(CMD_READ_R);
        collect_rsp(4 * (2 + rm * rn));
        pop_word(w);
        check_val("r_m", w, rm);
        pop_word(w);
        check_val("r_n", w, rn);
        for (int e = 0; e < rm * rn; e++) begin
            pop_word(w);
            check_val($sformatf("R[%0d][%0d]", e / rn, e % rn), w, r_ref[e]);
        end
    endtask

    task automatic unknown_check();
        byte_t b;
        repeat (2) begin
            b = byte_t'(rand_bits(8));
            if (b >= 8'h01 && b <= 8'h04) begin
                b = b ^ 8'h80;                       // Off the command codes
            end
            drive_byte(b);
        end
        idle_cycles(20);
        check_val("bytes after unknown command", rsp_q.size(), 0);
    endtask

    initial begin
        int m, k, n;
        rst_i      = 1'b1;
        rx_data_i  = '0;
        rx_valid_i = 1'b0;
        idle_cycles(3);                              // Reset for 3 cycles
        rst_i = 1'b0;
        idle_cycles(20);
        check_val("bytes after reset", rsp_q.size(), 0);
        read_check();                                // Empty R gives two zero words
        for (int r = 0; r < ROUNDS; r++) begin
            m = 1 + int'(rand_bits(3));
            k = 1 + int'(rand_bits(3));
            n = 1 + int'(rand_bits(3));
            load_matrix(1'b0, m, k);
            load_matrix(1'b1, k, n);
            multiply_check();
            read_check();
            if (r % 2 == 1) begin
                load_matrix(1'b1, k % MAX_DIM + 1, n);   // Rows differ from A's columns
                multiply_check();
                read_check();
            end
            if (r % 3 == 0) begin
                unknown_check();
            end
        end
        $display("all tests passed");
        $finish;
    end

    initial begin
        repeat (WDOG_CYCLES) @(posedge CLK100MHZ);
        $display("Watchdog expired, the design stopped responding");
        $display("tests failed");
        $fatal(1, "watchdog timeout");
    end

endmodule

/* tb.f */
mma_pkg.sv
matrix_ram.sv
word_rx.sv
word_tx.sv
mac_unit.sv
mma_controller.sv
mma_top.sv
tb_mma.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the matrix multiply testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=tb_mma_sim

verilator --binary --timing --assert -Wno-fatal --top-module tb_mma -f tb.f -o "$BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "tests failed" "$LOG"; then
    echo "Simulation FAILED"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
echo "Simulation PASSED"
exit 0
